/* rtl/seg_mem_pkg.sv */
// ------------------------------
// Geometry, vector types and the request format shared by every block
// of the segmented scratchpad. Import it inside a module body and use
// scoped names in module headers
// ------------------------------
package seg_mem_pkg;

    localparam int NUM_SEG = 4;                         // Logical segments across one row
    localparam int MEM_W   = 64;                        // Width of one physical row
    localparam int SEG_W   = MEM_W / NUM_SEG;           // Bits owned by each segment
    localparam int MEM_ELS = 64;                        // Rows in the backing SRAM
    localparam int ADDR_W  = $clog2(MEM_ELS);           // Row address width
    localparam int MASK_W  = SEG_W / 8;                 // One mask bit per byte of a segment

    typedef logic [ADDR_W-1:0]  addr_t;                 // Row address
    typedef logic [SEG_W-1:0]   seg_data_t;             // Data of a single segment
    typedef logic [MASK_W-1:0]  seg_mask_t;             // Byte mask of a single segment
    typedef logic [NUM_SEG-1:0] seg_vec_t;              // One flag per segment

    // Segment 0 sits in the low bits of the row
    typedef logic [NUM_SEG-1:0][SEG_W-1:0]  word_t;     // Full row split by segment
    typedef logic [NUM_SEG-1:0][MASK_W-1:0] wmask_t;    // Full byte mask split by segment

    // One access to the memory, shared address and direction for all segments
    typedef struct packed {
        seg_vec_t v;                                    // Segment takes part when set
        logic     w;                                    // High for write and low for read
        addr_t    addr;                                 // Row used by every segment
        wmask_t   mask;                                 // Byte enables for writes
        word_t    data;                                 // Write data
    } mem_req_t;

    // Clear sequencer states
    typedef enum logic {
        CLEAR,                                          // Sweeping zeros through the array
        READY                                           // Host traffic passes through
    } clr_state_e;

endpackage : seg_mem_pkg

/* rtl/seg_mem_bank.sv */
// ------------------------------
// Single-port synchronous SRAM with a byte write mask and one cycle of
// read latency. Serves as the backing array under the segmented wrapper
// ------------------------------
module seg_mem_bank (
    input  logic                clk_i,
    input  logic                en_i,       // Access strobe
    input  logic                w_i,        // Write when high
    input  seg_mem_pkg::addr_t  addr_i,
    input  seg_mem_pkg::wmask_t mask_i,     // Byte enables per segment
    input  seg_mem_pkg::word_t  data_i,
    output seg_mem_pkg::word_t  data_o      // Registered read data
);
    import seg_mem_pkg::*;

    word_t mem [MEM_ELS];                   // Storage array

    // Masked write. Only bytes with a set mask bit change
    always_ff @(posedge clk_i) begin
        if (en_i && w_i) begin
            for (int s = 0; s < NUM_SEG; s++) begin
                for (int b = 0; b < MASK_W; b++) begin
                    if (mask_i[s][b]) begin
                        mem[addr_i][s][8*b +: 8] <= data_i[s][8*b +: 8];   // One byte lane
                    end
                end
            end
        end
    end

    // Read port. The output register only moves on an enabled read
    always_ff @(posedge clk_i) begin
        if (en_i && !w_i) begin
            data_o <= mem[addr_i];          // Holds the row until the next read
        end
    end

endmodule : seg_mem_bank

/* rtl/seg_mem_segmented.sv */
// ------------------------------
// Splits one wide SRAM into logical segments that share an address and
// direction. Each segment has its own valid bit and keeps its last read
// word on the output until that segment reads again
// ------------------------------
module seg_mem_segmented (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  seg_mem_pkg::mem_req_t req_i,     // Access shared by all segments
    output seg_mem_pkg::word_t    rdata_o    // Per-segment last read data
);
    import seg_mem_pkg::*;

    wmask_t   mask_gated;                    // Byte mask with invalid segments removed
    word_t    bank_rdata;                    // Raw bank output
    seg_vec_t read_en;                       // Segment reads in this cycle
    seg_vec_t read_en_q;                     // Segment read in the previous cycle
    word_t    latch_q;                       // Held read data per segment

    // A segment that is not valid must not write any of its bytes
    always_comb begin
        for (int s = 0; s < NUM_SEG; s++) begin
            mask_gated[s] = req_i.mask[s] & {MASK_W{req_i.v[s]}};   // Gate each byte lane
        end
    end

    assign read_en = req_i.v & {NUM_SEG{~req_i.w}};  // Valid segments of a read

    seg_mem_bank u_bank (
        .clk_i  (clk_i),
        .en_i   (|req_i.v),                  // Any valid segment opens the row
        .w_i    (req_i.w),
        .addr_i (req_i.addr),
        .mask_i (mask_gated),
        .data_i (req_i.data),
        .data_o (bank_rdata)
    );

    // Remember which segments read so they pick up the bank output next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_en_q <= '0;
        end else begin
            read_en_q <= read_en;
        end
    end

    for (genvar s = 0; s < NUM_SEG; s++) begin : g_seg
        // Latch loads in the cycle the bank data is valid
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                latch_q[s] <= '0;            // Output reads zero before the first read
            end else if (read_en_q[s]) begin
                latch_q[s] <= bank_rdata[s];
            end
        end

        // Bypass so the fresh word shows with no extra cycle
        assign rdata_o[s] = read_en_q[s] ? bank_rdata[s] : latch_q[s];
    end

    // A valid access must carry a known row
    a_addr_known : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (|req_i.v) |-> !$isunknown(req_i.addr)
    ) else $error("segmented memory accessed with an unknown address");

    // A segment that did not read keeps its word on the output
    a_hold : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !read_en[0] |=> $stable(rdata_o[0])
    ) else $error("segment 0 output changed without a read");

endmodule : seg_mem_segmented

/* rtl/seg_mem_row_counter.sv */
// ------------------------------
// Row counter for the post-reset clear sweep. Steps once per inc_i and
// flags the last row of the array
// ------------------------------
module seg_mem_row_counter (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               inc_i,      // Advance to the next row
    output seg_mem_pkg::addr_t row_o,      // Row being cleared
    output logic               last_o      // High on the final row
);
    import seg_mem_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_o <= '0;                   // Sweep starts at row zero
        end else if (inc_i) begin
            row_o <= addr_t'(row_o + 1'b1);  // Wraps to zero after the last row
        end
    end

    assign last_o = (row_o == addr_t'(MEM_ELS - 1));

    // The sweep ends on the last row, so counting must stop right after it
    a_no_wrap : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (last_o && inc_i) |=> !inc_i
    ) else $error("row counter kept counting past the last row");

endmodule : seg_mem_row_counter

/* rtl/seg_mem_clear_fsm.sv */
// ------------------------------
// Clear sequencer. After reset it writes zero to every row and holds
// ready low, then forwards host requests unchanged
// ------------------------------
module seg_mem_clear_fsm (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  seg_mem_pkg::mem_req_t req_i,       // Host request
    input  logic                  last_i,      // Counter is on the last row
    output logic                  inc_o,       // Step the row counter
    input  seg_mem_pkg::addr_t    row_i,       // Row to clear
    output logic                  ready_o,     // Host requests are accepted
    output seg_mem_pkg::mem_req_t mem_req_o    // Request to the memory
);
    import seg_mem_pkg::*;

    clr_state_e state_q;                       // Current state
    clr_state_e state_d;                       // Next state
    mem_req_t   clr_req;                       // Zero write for the current row

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= CLEAR;                  // The array holds garbage after power up
        end else begin
            state_q <= state_d;
        end
    end

    // Leave the sweep on the edge that writes the last row
    always_comb begin
        state_d = state_q;
        if (state_q == CLEAR && last_i) begin
            state_d = READY;
        end
    end

    // Whole row written with zeros in every byte
    always_comb begin
        clr_req      = '0;
        clr_req.v    = '1;                     // All segments take part
        clr_req.w    = 1'b1;
        clr_req.addr = row_i;
        clr_req.mask = '1;                     // Every byte lane enabled
    end

    assign inc_o     = (state_q == CLEAR);     // One row per cycle during the sweep
    assign ready_o   = (state_q == READY);
    assign mem_req_o = (state_q == CLEAR) ? clr_req : req_i;  // Host traffic dropped while clearing

    // Clearing happens once per reset
    a_stay_ready : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (state_q == READY) |=> (state_q == READY)
    ) else $error("clear sequencer left the READY state");

endmodule : seg_mem_clear_fsm

/* rtl/seg_mem_top.sv */
// ------------------------------
// Segmented scratchpad top level. Clears the array after reset and then
// serves host reads and writes with ready_o high
// ------------------------------
module seg_mem_top (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  seg_mem_pkg::mem_req_t req_i,     // Host request that is dropped while ready_o is low
    output logic                  ready_o,   // Clear sweep finished
    output seg_mem_pkg::word_t    rdata_o    // Latched read data per segment
);
    import seg_mem_pkg::*;

    mem_req_t mem_req;                       // Selected clear or host request
    logic     inc;                           // Counter step
    logic     last;                          // Counter on the final row
    addr_t    row;                           // Row being cleared

    seg_mem_clear_fsm u_clear_fsm (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .last_i    (last),
        .inc_o     (inc),
        .row_i     (row),
        .ready_o   (ready_o),
        .mem_req_o (mem_req)
    );

    seg_mem_row_counter u_row_counter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .inc_i    (inc),
        .row_o    (row),
        .last_o   (last)
    );

    seg_mem_segmented u_segmented (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (mem_req),
        .rdata_o  (rdata_o)
    );

endmodule : seg_mem_top

/* tests/seg_mem_tb.sv */
// ------------------------------
// Random-stimulus testbench for the segmented scratchpad. Checks the
// clear sweep and ready timing, then compares read data every cycle
// against a reference model of the array and the segment latches
// ------------------------------
module seg_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import seg_mem_pkg::*;

    localparam int          RESET_CYC   = 16;                       // Cycles with reset held low
    localparam int          HOST_OPS    = 600;                      // Host cycles after the sweep
    localparam int          RAND_OPS    = HOST_OPS - 2 * MEM_ELS;   // Two full sweeps fit inside
    localparam int          TIMEOUT_CYC = RESET_CYC + MEM_ELS + HOST_OPS + 100;
    localparam int unsigned SEED        = 32'ha565;

    logic        clk;
    logic        arst_n;
    mem_req_t    req;                       // Host request into the DUT
    logic        ready;
    word_t       rdata;

    word_t       model_mem [MEM_ELS];       // Expected array contents
    word_t       model_rd;                  // Expected latched read data
    mem_req_t    pend_req;                  // Request that the next edge samples
    logic        pend_acc;                  // That request lands in READY
    int          edge_cnt;                  // Rising edges since reset release
    int          cyc_cnt;                   // Watchdog count
    int          val_errs;
    int          other_errs;

    seg_mem_top UUT (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .req_i    (req),
        .ready_o  (ready),
        .rdata_o  (rdata)
    );

    always #2 clk = ~clk;                   // 4 ns period

    // Mix of idle cycles, masked writes and partial or full reads
    function automatic mem_req_t rand_req();
        mem_req_t    r;
        int unsigned kind;
        kind   = $urandom_range(9, 0);
        r.w    = (kind < 2) ? 1'($urandom_range(1, 0)) : (kind < 6);
        r.v    = (kind < 2) ? '0 : seg_vec_t'($urandom);   // Idle has no valid segment
        if (kind == 9) begin
            r.v = '1;                       // Some reads refresh every segment
        end
        if ($urandom_range(1, 0) == 0) begin
            r.addr = addr_t'($urandom_range(7, 0));         // Crowd a few rows to get hits
        end else begin
            r.addr = addr_t'($urandom);
        end
        r.mask = wmask_t'($urandom);
        r.data = {$urandom, $urandom};
        return r;
    endfunction

    // Read of one whole row with every segment valid
    function automatic mem_req_t read_req(input addr_t a);
        mem_req_t r;
        r      = '0;
        r.v    = '1;
        r.addr = a;
        return r;
    endfunction

    // Byte-wise view of the access rules for one accepted request
    task automatic model_apply(input mem_req_t r);
        logic [MEM_W-1:0]          row_bits;
        logic [MEM_W-1:0]          data_bits;
        logic [NUM_SEG*MASK_W-1:0] mask_bits;
        row_bits  = model_mem[r.addr];
        data_bits = r.data;
        mask_bits = r.mask;
        if (r.w) begin
            for (int k = 0; k < NUM_SEG * MASK_W; k++) begin
                if (r.v[k / MASK_W] && mask_bits[k]) begin
                    row_bits[8*k +: 8] = data_bits[8*k +: 8];   // Byte k lies in segment k/2
                end
            end
            model_mem[r.addr] = row_bits;
        end else begin
            for (int s = 0; s < NUM_SEG; s++) begin
                if (r.v[s]) begin
                    model_rd[s] = model_mem[r.addr][s];        // Only valid segments reload
                end
            end
        end
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            val_errs++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_ready(input logic act, input logic exp);
        if (act !== exp) begin
            val_errs++;
            $display("CHECK FAILED ready_o expected %h actual %h at %0t", exp, act, $time);
        end
    endtask

    // Drive one request and check the result of the one sampled at this edge
    task automatic run_cycle(input mem_req_t r);
        logic exp_ready;
        @(posedge clk);
        edge_cnt++;
        req <= r;
        if (pend_acc) begin
            model_apply(pend_req);          // The DUT took it at this edge
        end
        @(negedge clk);
        exp_ready = (edge_cnt >= MEM_ELS);  // Sweep writes one row per edge
        check_ready(ready, exp_ready);
        check_word("rdata_o", rdata, model_rd);
        pend_req = r;
        pend_acc = exp_ready;               // The next edge accepts it only when ready is high now
    endtask

    task automatic finish_run();
        $display("Summary: %0d value errors, %0d other errors", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        req        = '0;
        pend_req   = '0;
        pend_acc   = 1'b0;
        edge_cnt   = 0;
        val_errs   = 0;
        other_errs = 0;
        model_rd   = '0;                    // Latches reset to zero
        void'($urandom(SEED));
        for (int a = 0; a < MEM_ELS; a++) begin
            model_mem[a] = '0;              // State after the clear sweep
        end
        repeat (RESET_CYC) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_ready(ready, 1'b0);
        check_word("rdata_o", rdata, '0);
        // Random traffic while ready is low must be dropped
        for (int i = 1; i < MEM_ELS; i++) begin
            run_cycle(rand_req());
        end
        // Every row reads zero once the sweep is done
        for (int a = 0; a < MEM_ELS; a++) begin
            run_cycle(read_req(addr_t'(a)));
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            run_cycle(rand_req());
        end
        // Final sweep compares the whole array with the model
        for (int a = 0; a < MEM_ELS; a++) begin
            run_cycle(read_req(addr_t'(a)));
        end
        run_cycle('0);                      // Let the last read come back
        finish_run();
    end

    // Watchdog covering reset, the sweep, host traffic and margin
    initial begin
        cyc_cnt = 0;
        while (cyc_cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            cyc_cnt++;
        end
        other_errs++;
        $display("ERROR: run did not finish within %0d clock cycles", TIMEOUT_CYC);
        finish_run();
    end

endmodule : seg_mem_tb

/* seg_mem.f */
rtl/seg_mem_pkg.sv
rtl/seg_mem_bank.sv
rtl/seg_mem_segmented.sv
rtl/seg_mem_row_counter.sv
rtl/seg_mem_clear_fsm.sv
rtl/seg_mem_top.sv
tests/seg_mem_tb.sv

/* Bender.yml */
package:
  name: seg_mem

sources:
  - rtl/seg_mem_pkg.sv
  - rtl/seg_mem_bank.sv
  - rtl/seg_mem_segmented.sv
  - rtl/seg_mem_row_counter.sv
  - rtl/seg_mem_clear_fsm.sv
  - rtl/seg_mem_top.sv
  - target: test
    files:
      - tests/seg_mem_tb.sv
